//--- i3c_target_defs.svh
// Widths and bit counts for the I3C write-only target; timing values count clk_i cycles
`ifndef I3C_TARGET_DEFS_SVH
`define I3C_TARGET_DEFS_SVH

// 7-bit target address, the address byte adds RnW
`define I3C_ADDR_W 7

// SDR byte on the bus
`define I3C_BYTE_W 8

// Flops on each SCL/SDA input before edge detection
`define I3C_SYNC_STAGES 2

// Width of the hold timing input
`define I3C_TIMING_W 20

// SCL bits per bus word, 8 data plus ACK or T-bit
`define I3C_WORD_BITS 9

`endif

//--- i3c_target_pkg.sv
// Bus and queue types of the write-only I3C target; SDR private writes only
`include "i3c_target_defs.svh"

package i3c_target_pkg;

  // One-cycle pulses from the bus monitor
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
    logic scl_rise;
    logic scl_fall;
  } bus_event_t;

  // Dynamic address takes precedence once valid
  typedef struct packed {
    logic [`I3C_ADDR_W-1:0] sta_addr;
    logic                   sta_valid;
    logic [`I3C_ADDR_W-1:0] dyn_addr;
    logic                   dyn_valid;
  } addr_cfg_t;

  // Word received from the bus, valid is a strobe
  typedef struct packed {
    logic [`I3C_BYTE_W-1:0] data;
    logic                   ninth;
    logic                   valid;
  } bus_word_t;

  // Write side of the RX queue
  typedef struct packed {
    logic                   wvalid;
    logic [`I3C_BYTE_W-1:0] wdata;
    logic                   last;
  } rx_queue_wr_t;

  typedef enum logic [2:0] {
    Idle,
    Addr,
    AddrAck,
    Data,
    Ignore
  } tgt_state_e;

endpackage

//--- bus_monitor.sv
// SCL and SDA must idle high; events appear SYNC_STAGES plus one cycle after the pins change
`include "i3c_target_defs.svh"

module bus_monitor (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       scl_i,
  input  logic                       sda_i,
  output i3c_target_pkg::bus_event_t events_o,
  output logic                       sda_sync_o
);
  import i3c_target_pkg::*;

  logic [`I3C_SYNC_STAGES-1:0] scl_sync_q;
  logic [`I3C_SYNC_STAGES-1:0] sda_sync_q;
  logic                        scl_s;
  logic                        sda_s;
  logic                        scl_prev_q;
  logic                        sda_prev_q;
  logic                        xfer_open_q;
  bus_event_t                  events_d;
  bus_event_t                  events_q;

  assign scl_s = scl_sync_q[`I3C_SYNC_STAGES-1];
  assign sda_s = sda_sync_q[`I3C_SYNC_STAGES-1];

  // Synchronizers reset to the idle bus level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[`I3C_SYNC_STAGES-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[`I3C_SYNC_STAGES-2:0], sda_i};
      scl_prev_q <= scl_s;
      sda_prev_q <= sda_s;
    end
  end

  always_comb begin
    events_d          = '0;
    events_d.scl_rise = scl_s & ~scl_prev_q;
    events_d.scl_fall = ~scl_s & scl_prev_q;
    // SDA may only move with SCL high for a bus condition
    if (scl_s && scl_prev_q) begin
      if (sda_prev_q && !sda_s) begin
        events_d.start  = ~xfer_open_q;
        events_d.rstart = xfer_open_q;
      end
      if (!sda_prev_q && sda_s) begin
        events_d.stop = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      events_q    <= '0;
      xfer_open_q <= 1'b0;
    end else begin
      events_q <= events_d;
      if (events_d.start) begin
        xfer_open_q <= 1'b1;
      end else if (events_d.stop) begin
        xfer_open_q <= 1'b0;
      end
    end
  end

  assign events_o = events_q;

  // Delayed copy lines up with the registered events
  assign sda_sync_o = sda_prev_q;

endmodule

//--- bus_rx_shifter.sv
// Samples SDA on SCL rise; the address word strobes after 8 bits and its ACK bit is skipped
`include "i3c_target_defs.svh"

module bus_rx_shifter (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  i3c_target_pkg::bus_event_t events_i,
  input  logic                       sda_i,
  input  logic                       addr_phase_i,
  output i3c_target_pkg::bus_word_t  word_o
);

  localparam int unsigned CntW = $clog2(`I3C_WORD_BITS);
  localparam logic [CntW-1:0] LastBit = CntW'(`I3C_WORD_BITS - 1);
  localparam logic [CntW-1:0] AddrLastBit = CntW'(`I3C_WORD_BITS - 2);

  logic [`I3C_BYTE_W-1:0] shift_q;
  logic [CntW-1:0]        bit_cnt_q;
  logic                   skip_ack_q;
  logic                   addr_done;
  logic                   word_done;
  logic                   valid_q;
  logic [`I3C_BYTE_W-1:0] data_q;
  logic                   ninth_q;

  assign addr_done = events_i.scl_rise & addr_phase_i & (bit_cnt_q == AddrLastBit);
  assign word_done = events_i.scl_rise & (bit_cnt_q == LastBit);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt_q  <= '0;
      skip_ack_q <= 1'b0;
      valid_q    <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (events_i.start || events_i.rstart) begin
        bit_cnt_q  <= '0;
        skip_ack_q <= 1'b0;
      end else if (word_done) begin
        bit_cnt_q  <= '0;
        skip_ack_q <= 1'b0;
        // Ninth bit of the address is the ACK, not ours to report
        valid_q    <= ~skip_ack_q;
      end else if (events_i.scl_rise) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
        if (addr_done) begin
          skip_ack_q <= 1'b1;
          valid_q    <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (events_i.scl_rise) begin
      shift_q <= {shift_q[`I3C_BYTE_W-2:0], sda_i};
    end
    if (addr_done) begin
      data_q  <= {shift_q[`I3C_BYTE_W-2:0], sda_i};
      ninth_q <= 1'b0;
    end else if (word_done) begin
      data_q  <= shift_q;
      ninth_q <= sda_i;
    end
  end

  assign word_o = '{data: data_q, ninth: ninth_q, valid: valid_q};

endmodule

//--- target_fsm.sv
// Private writes only; rx_queue_full_i is sampled at the address byte and never throttles data
`include "i3c_target_defs.svh"

module target_fsm (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  i3c_target_pkg::bus_event_t   events_i,
  input  i3c_target_pkg::bus_word_t    word_i,
  input  i3c_target_pkg::addr_cfg_t    addr_cfg_i,
  input  logic                         rx_queue_full_i,
  output logic                         addr_phase_o,
  output logic                         ack_req_o,
  output i3c_target_pkg::rx_queue_wr_t rx_queue_o,
  output logic                         parity_err_o,
  output logic [`I3C_BYTE_W-1:0]       bus_addr_o,
  output logic                         bus_addr_valid_o
);
  import i3c_target_pkg::*;

  tgt_state_e             state_q;
  tgt_state_e             state_d;
  logic [`I3C_ADDR_W-1:0] addr7;
  logic                   addr_rnw;
  logic                   addr_match;
  logic                   addr_ack;
  logic                   addr_word;
  logic                   data_word;
  logic                   parity_ok;
  logic                   end_of_xfer;
  logic [`I3C_BYTE_W-1:0] held_q;
  logic                   held_valid_q;
  logic                   wvalid_q;
  logic [`I3C_BYTE_W-1:0] wdata_q;
  logic                   last_q;
  logic                   parity_err_q;
  logic [`I3C_BYTE_W-1:0] addr_byte_q;
  logic                   addr_valid_q;

  assign addr7    = word_i.data[`I3C_BYTE_W-1:1];
  assign addr_rnw = word_i.data[0];

  // Static address only counts until a dynamic one is assigned
  assign addr_match = addr_cfg_i.dyn_valid ? (addr7 == addr_cfg_i.dyn_addr) :
                      (addr_cfg_i.sta_valid && (addr7 == addr_cfg_i.sta_addr));
  assign addr_ack   = addr_match & ~addr_rnw & ~rx_queue_full_i;

  assign addr_word   = (state_q == Addr) & word_i.valid;
  assign data_word   = (state_q == Data) & word_i.valid;
  // T-bit gives odd parity over the byte
  assign parity_ok   = (word_i.ninth == ~^word_i.data);
  assign end_of_xfer = (state_q == Data) & (events_i.stop | events_i.rstart);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (events_i.start) state_d = Addr;
      end
      Addr: begin
        if (word_i.valid) state_d = addr_ack ? AddrAck : Ignore;
      end
      AddrAck: begin
        // Fall after bit 8 opens the ACK bit
        if (events_i.scl_fall) state_d = Data;
      end
      default: ;
    endcase
    if (events_i.rstart) state_d = Addr;
    if (events_i.stop) state_d = Idle;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= Idle;
      held_valid_q <= 1'b0;
      wvalid_q     <= 1'b0;
      parity_err_q <= 1'b0;
      addr_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      wvalid_q     <= 1'b0;
      parity_err_q <= 1'b0;
      addr_valid_q <= addr_word;
      if (data_word) begin
        if (parity_ok) begin
          held_valid_q <= 1'b1;
          wvalid_q     <= held_valid_q;
        end else begin
          parity_err_q <= 1'b1;
        end
      end
      if (end_of_xfer) begin
        held_valid_q <= 1'b0;
        wvalid_q     <= held_valid_q;
      end
    end
  end

  // One byte is held back until we know whether it closes the transfer
  always_ff @(posedge clk_i) begin
    if (addr_word) begin
      addr_byte_q <= word_i.data;
    end
    if (data_word && parity_ok) begin
      held_q  <= word_i.data;
      wdata_q <= held_q;
      last_q  <= 1'b0;
    end
    if (end_of_xfer) begin
      wdata_q <= held_q;
      last_q  <= 1'b1;
    end
  end

  assign addr_phase_o     = (state_q == Addr);
  assign ack_req_o        = (state_q == AddrAck);
  assign rx_queue_o       = '{wvalid: wvalid_q, wdata: wdata_q, last: last_q};
  assign parity_err_o     = parity_err_q;
  assign bus_addr_o       = addr_byte_q;
  assign bus_addr_valid_o = addr_valid_q;

endmodule

//--- sda_driver.sv
// Open-drain only; SDA changes t_hd_dat_i cycles after the SCL fall event, 0 and 1 both act as one
`include "i3c_target_defs.svh"

module sda_driver (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  i3c_target_pkg::bus_event_t events_i,
  input  logic                       ack_req_i,
  input  logic [`I3C_TIMING_W-1:0]   t_hd_dat_i,
  output logic                       sda_o
);

  logic [`I3C_TIMING_W-1:0] hold_cnt_q;
  logic                     hold_busy_q;
  logic                     ack_armed_q;
  logic                     hold_last;

  assign hold_last = (hold_cnt_q[`I3C_TIMING_W-1:1] == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_cnt_q  <= '0;
      hold_busy_q <= 1'b0;
      ack_armed_q <= 1'b0;
      sda_o       <= 1'b1;
    end else if (events_i.stop) begin
      hold_busy_q <= 1'b0;
      ack_armed_q <= 1'b0;
      sda_o       <= 1'b1;
    end else if (events_i.scl_fall) begin
      hold_cnt_q  <= t_hd_dat_i;
      hold_busy_q <= 1'b1;
      ack_armed_q <= ack_req_i;
    end else if (hold_busy_q) begin
      if (hold_last) begin
        hold_busy_q <= 1'b0;
        sda_o       <= ~ack_armed_q;
      end else begin
        hold_cnt_q <= hold_cnt_q - 1'b1;
      end
    end
  end

endmodule

//--- i3c_target_top.sv
// ctrl_sda_i is the resolved bus level; the DUT only pulls SDA low, SCL is input only
`include "i3c_target_defs.svh"

module i3c_target_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         ctrl_scl_i,
  input  logic                         ctrl_sda_i,
  output logic                         ctrl_sda_o,
  input  i3c_target_pkg::addr_cfg_t    addr_cfg_i,
  input  logic [`I3C_TIMING_W-1:0]     t_hd_dat_i,
  input  logic                         rx_queue_full_i,
  output i3c_target_pkg::rx_queue_wr_t rx_queue_o,
  output logic                         bus_start_o,
  output logic                         bus_rstart_o,
  output logic                         bus_stop_o,
  output logic [`I3C_BYTE_W-1:0]       bus_addr_o,
  output logic                         bus_addr_valid_o,
  output logic                         parity_err_o
);
  import i3c_target_pkg::*;

  bus_event_t events;
  bus_word_t  word;
  logic       sda_bus;
  logic       sda_sync;
  logic       addr_phase;
  logic       ack_req;
  logic       sda_drv;

  // Own pull-down is part of the wired-AND we observe
  assign sda_bus    = ctrl_sda_i & sda_drv;
  assign ctrl_sda_o = sda_drv;

  bus_monitor u_bus_monitor (
    .clk_i,
    .rst_ni,
    .scl_i      (ctrl_scl_i),
    .sda_i      (sda_bus),
    .events_o   (events),
    .sda_sync_o (sda_sync)
  );

  bus_rx_shifter u_bus_rx_shifter (
    .clk_i,
    .rst_ni,
    .events_i     (events),
    .sda_i        (sda_sync),
    .addr_phase_i (addr_phase),
    .word_o       (word)
  );

  target_fsm u_target_fsm (
    .clk_i,
    .rst_ni,
    .events_i         (events),
    .word_i           (word),
    .addr_cfg_i,
    .rx_queue_full_i,
    .addr_phase_o     (addr_phase),
    .ack_req_o        (ack_req),
    .rx_queue_o,
    .parity_err_o,
    .bus_addr_o,
    .bus_addr_valid_o
  );

  sda_driver u_sda_driver (
    .clk_i,
    .rst_ni,
    .events_i   (events),
    .ack_req_i  (ack_req),
    .t_hd_dat_i,
    .sda_o      (sda_drv)
  );

  assign bus_start_o  = events.start;
  assign bus_rstart_o = events.rstart;
  assign bus_stop_o   = events.stop;

endmodule

//--- tb_i3c_target.sv
// Transfers and configuration come from i3c_target_patterns.txt; SCL half period is 10 cycles
`include "i3c_target_defs.svh"

module tb_i3c_target;
  timeunit 1ns;
  timeprecision 100ps;
  import i3c_target_pkg::*;

  localparam int HalfPeriod = 10;
  localparam int Fields = 13;
  localparam int NumXfers = 11;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     scl_m;
  logic                     sda_m;
  logic                     sda_dut;
  logic                     sda_bus;
  addr_cfg_t                addr_cfg;
  logic [`I3C_TIMING_W-1:0] t_hd_dat;
  logic                     rx_full;
  rx_queue_wr_t             rx_queue;
  logic                     bus_start;
  logic                     bus_rstart;
  logic                     bus_stop;
  logic [`I3C_BYTE_W-1:0]   bus_addr;
  logic                     bus_addr_valid;
  logic                     parity_err;

  logic [7:0] pat_mem [0:NumXfers*Fields-1];
  logic [8:0] got_q[$];
  int         n_start;
  int         n_rstart;
  int         n_stop;
  int         n_parity;
  int         n_addr;
  logic [7:0] addr_seen;
  int         errors;
  int         checks;
  int         cycles;
  int         limit;
  int         seed;

  // Wired-AND of master and target
  assign sda_bus = sda_m & sda_dut;

  i3c_target_top DUT (
    .clk_i,
    .rst_ni,
    .ctrl_scl_i       (scl_m),
    .ctrl_sda_i       (sda_bus),
    .ctrl_sda_o       (sda_dut),
    .addr_cfg_i       (addr_cfg),
    .t_hd_dat_i       (t_hd_dat),
    .rx_queue_full_i  (rx_full),
    .rx_queue_o       (rx_queue),
    .bus_start_o      (bus_start),
    .bus_rstart_o     (bus_rstart),
    .bus_stop_o       (bus_stop),
    .bus_addr_o       (bus_addr),
    .bus_addr_valid_o (bus_addr_valid),
    .parity_err_o     (parity_err)
  );

  always #2 clk_i = ~clk_i;

  // Collects RX writes and pulse counts
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (rx_queue.wvalid) got_q.push_back({rx_queue.last, rx_queue.wdata});
      if (bus_start) n_start++;
      if (bus_rstart) n_rstart++;
      if (bus_stop) n_stop++;
      if (parity_err) n_parity++;
      if (bus_addr_valid) begin
        n_addr++;
        addr_seen = bus_addr;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  // Data moves while SCL is low and is read late in the high phase
  task automatic drive_bit(input logic b, output logic level);
    wait_cycles(2);
    sda_m <= b;
    wait_cycles(HalfPeriod - 2);
    scl_m <= 1'b1;
    wait_cycles(HalfPeriod - 1);
    @(negedge clk_i);
    level = sda_bus;
    @(posedge clk_i);
    scl_m <= 1'b0;
  endtask

  task automatic send_start();
    wait_cycles(HalfPeriod);
    sda_m <= 1'b0;
    wait_cycles(HalfPeriod);
    scl_m <= 1'b0;
  endtask

  task automatic send_stop();
    wait_cycles(2);
    sda_m <= 1'b0;
    wait_cycles(HalfPeriod - 2);
    scl_m <= 1'b1;
    wait_cycles(HalfPeriod);
    sda_m <= 1'b1;
    wait_cycles(HalfPeriod);
  endtask

  task automatic send_rstart();
    wait_cycles(2);
    sda_m <= 1'b1;
    wait_cycles(HalfPeriod - 2);
    scl_m <= 1'b1;
    wait_cycles(HalfPeriod);
    sda_m <= 1'b0;
    wait_cycles(HalfPeriod);
    scl_m <= 1'b0;
  endtask

  initial begin
    logic [7:0] f [0:Fields-1];
    logic [8:0] exp_q[$];
    logic       lvl;
    logic       ack_exp;
    logic       ack_seen;
    logic       chained;
    logic       rs;
    int         bits;
    int         cnt;
    int         n_bad;
    int         base_err;
    int         b_start;
    int         b_rstart;
    int         b_stop;
    int         b_parity;
    int         b_addr;

    clk_i = 1'b0;
    rst_ni = 1'b0;
    scl_m = 1'b1;
    sda_m = 1'b1;
    addr_cfg = '0;
    rx_full = 1'b0;
    errors = 0;
    checks = 0;
    cycles = 0;
    limit = 0;
    seed = 32'hd2a7;
    t_hd_dat = `I3C_TIMING_W'(1 + ($unsigned($random(seed)) % 3));
    $readmemh("i3c_target_patterns.txt", pat_mem);

    bits = 0;
    for (int i = 0; i < NumXfers; i++) begin
      bits += 9 + 9 * int'(pat_mem[i*Fields+7]) + 4;
    end
    limit = bits * 2 * HalfPeriod + 200;

    wait_cycles(5);
    rst_ni <= 1'b1;
    wait_cycles(2);

    chained = 1'b0;
    for (int i = 0; i < NumXfers; i++) begin
      for (int k = 0; k < Fields; k++) f[k] = pat_mem[i*Fields+k];
      rs = f[6][0] && (i < NumXfers - 1);
      cnt = int'(f[7]);
      addr_cfg <= '{sta_addr: f[0][6:0], sta_valid: 1'b1, dyn_addr: f[1][6:0],
                    dyn_valid: f[2][0]};
      rx_full <= f[3][0];

      // Reference model
      ack_exp = (f[2][0] ? (f[4][6:0] == f[1][6:0]) : (f[4][6:0] == f[0][6:0])) &&
                !f[5][0] && !f[3][0];
      exp_q.delete();
      n_bad = 0;
      if (ack_exp) begin
        for (int j = 0; j < cnt; j++) begin
          if (f[12][j]) n_bad++;
          else exp_q.push_back({1'b0, f[8+j]});
        end
        if (exp_q.size() > 0) exp_q[exp_q.size()-1][8] = 1'b1;
      end

      base_err = errors;
      b_start = n_start;
      b_rstart = n_rstart;
      b_stop = n_stop;
      b_parity = n_parity;
      b_addr = n_addr;
      got_q.delete();

      if (!chained) send_start();
      for (int k = 6; k >= 0; k--) drive_bit(f[4][k], lvl);
      drive_bit(f[5][0], lvl);
      drive_bit(1'b1, lvl);
      ack_seen = ~lvl;
      for (int j = 0; j < cnt; j++) begin
        for (int k = 7; k >= 0; k--) drive_bit(f[8+j][k], lvl);
        drive_bit((~^f[8+j]) ^ f[12][j], lvl);
      end
      if (rs) send_rstart();
      else send_stop();
      wait_cycles(4);

      check_value("ctrl_sda_o ack", 32'(ack_seen), 32'(ack_exp));
      check_value("rx_queue_o writes", 32'(got_q.size()), 32'(exp_q.size()));
      for (int j = 0; j < exp_q.size() && j < got_q.size(); j++) begin
        check_value("rx_queue_o.wdata", 32'(got_q[j][7:0]), 32'(exp_q[j][7:0]));
        check_value("rx_queue_o.last", 32'(got_q[j][8]), 32'(exp_q[j][8]));
      end
      check_value("parity_err_o pulses", 32'(n_parity - b_parity), 32'(n_bad));
      check_value("bus_addr_valid_o pulses", 32'(n_addr - b_addr), 32'd1);
      check_value("bus_addr_o", 32'(addr_seen), 32'({f[4][6:0], f[5][0]}));
      check_value("bus_start_o pulses", 32'(n_start - b_start), 32'(!chained));
      check_value("bus_rstart_o pulses", 32'(n_rstart - b_rstart), 32'(rs));
      check_value("bus_stop_o pulses", 32'(n_stop - b_stop), 32'(!rs));
      $display("test %0d: %s", i, (errors == base_err) ? "ok" : "mismatch");
      chained = rs;
    end

    $display("tests %0d, checks %0d, errors %0d", NumXfers, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- i3c_target_patterns.txt
// sta_addr dyn_addr dyn_valid rx_full addr7 rnw rstart count byte0 byte1 byte2 byte3 bad_mask
// One transfer per line, rstart 1 chains into the next line
2A 35 00 00 2A 00 00 03 11 A5 3C 00 00
2A 35 01 00 2A 00 00 02 12 34 00 00 00
2A 35 01 00 35 00 00 04 DE AD BE EF 00
2A 35 01 00 35 00 00 03 01 02 03 00 02
2A 35 01 00 35 00 00 03 55 66 77 00 04
2A 35 01 00 35 00 01 02 81 82 00 00 00
2A 35 01 00 35 00 00 01 99 00 00 00 00
2A 35 01 00 35 01 00 00 00 00 00 00 00
2A 35 01 01 35 00 00 02 C3 C4 00 00 00
2A 35 00 00 2A 00 01 01 F0 00 00 00 00
2A 35 00 00 11 00 00 01 0F 00 00 00 00

//--- compile.f
+incdir+.
i3c_target_pkg.sv
bus_monitor.sv
bus_rx_shifter.sv
target_fsm.sv
sda_driver.sv
i3c_target_top.sv
tb_i3c_target.sv

//--- Makefile
# Verilator flow for the I3C target testbench

VERILATOR ?= verilator
TOP       ?= tb_i3c_target
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  := TESTBENCH FAILED
PASS_MSG  := TESTBENCH PASSED

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
